// File: dcachePkg.sv
package dcachePkg;

	typedef logic [31:0] addrT;     // byte address
	typedef logic [27:0] tileAddrT; // byte address bits 31:4
	typedef logic [127:0] tileT;
	typedef logic [63:0] wordT;

	// bit 4 store, bit 3 load, bit 2 unsigned, bits 1:0 size
	typedef logic [4:0] opmT;
	typedef logic [1:0] okT;

	// {tile address, dirty, valid}
	typedef logic [29:0] tagT;

	localparam okT okReady = 2'b00;
	localparam okT okOk = 2'b01;
	localparam okT okHold = 2'b10;

	// memory port opcodes
	localparam opmT opmReady = 5'b00000;
	localparam opmT opmRdTile = 5'b01111;
	localparam opmT opmWrTile = 5'b10111;

	localparam int defaultBankDepth = 64;

	// valid entry for a tile
	function automatic tagT makeTag(input tileAddrT tile, input logic dirty);
		return {tile, dirty, 1'b1};
	endfunction

	function automatic tileAddrT tagTile(input tagT tag);
		return tag[29:2];
	endfunction

	function automatic logic tagDirty(input tagT tag);
		return tag[1];
	endfunction

	function automatic logic tagValid(input tagT tag);
		return tag[0];
	endfunction

endpackage

// File: dcBankIf.sv
`timescale 1ns/1ps

interface dcBankIf import dcachePkg::*; #(
	parameter int bankDepth = defaultBankDepth
) ();
	localparam int ixW = $clog2(bankDepth);

	logic [ixW-1:0] rdIx;
	logic wrEn;
	logic [ixW-1:0] wrIx;
	tileT wrData;
	tagT wrTag;

	// valid one cycle after rdIx
	tileT rdData;
	tagT rdTag;

	modport ctrl (output rdIx, wrEn, wrIx, wrData, wrTag, input rdData, rdTag);
	modport bank (input rdIx, wrEn, wrIx, wrData, wrTag, output rdData, rdTag);

endinterface

// File: dcacheBank.sv
`timescale 1ns/1ps

module dcacheBank import dcachePkg::*; #(
	parameter int bankDepth = defaultBankDepth
) (
	input logic clock,
	input logic arstN,
	dcBankIf.bank port
);
	localparam int ixW = $clog2(bankDepth);

	tileT dataMem [bankDepth];
	logic [29:1] tagMem [bankDepth]; // tile address and dirty bit
	logic [bankDepth-1:0] validBits;

	tileT rdDataQ;
	logic [29:1] rdTagQ;
	logic rdValidQ;
	logic [ixW-1:0] rdIxQ;

	// last write, for a read issued at the same edge
	logic lastWrEn;
	logic [ixW-1:0] lastIx;
	tileT lastData;
	tagT lastTag;
	logic fwd;

	always_ff @(posedge clock)
	begin
		rdDataQ <= dataMem[port.rdIx];
		rdTagQ <= tagMem[port.rdIx];
		rdIxQ <= port.rdIx;
		lastIx <= port.wrIx;
		lastData <= port.wrData;
		lastTag <= port.wrTag;
		if (port.wrEn)
		begin
			dataMem[port.wrIx] <= port.wrData;
			tagMem[port.wrIx] <= port.wrTag[29:1];
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			validBits <= '0;
			rdValidQ <= 1'b0;
			lastWrEn <= 1'b0;
		end
		else
		begin
			rdValidQ <= validBits[port.rdIx];
			lastWrEn <= port.wrEn;
			if (port.wrEn)
				validBits[port.wrIx] <= tagValid(port.wrTag);
		end
	end

	assign fwd = lastWrEn && (lastIx == rdIxQ);
	assign port.rdData = fwd ? lastData : rdDataQ;
	assign port.rdTag = fwd ? lastTag : {rdTagQ, rdValidQ};

endmodule

// File: dcacheAlign.sv
`timescale 1ns/1ps

module dcacheAlign import dcachePkg::*; (
	input logic clock,
	input logic [2:0] byteIx,
	input logic [1:0] window,
	input opmT opm,
	input wordT storeVal,
	input tileT tileA,
	input tileT tileB,
	output wordT loadVal,
	output tileT newTileA,
	output tileT newTileB,
	output logic touchA,
	output logic touchB
);
	localparam tileT laneMask = {64'h0, {64{1'b1}}};

	tileT win;
	tileT shifted;
	wordT exData;
	wordT merged;
	logic [5:0] shift;

	tileT winQ;    // window seen in the first store cycle
	wordT mergedQ;
	tileT winW;

	assign shift = {byteIx, 3'b000};

	// two neighbouring tiles, lower address first
	always_comb
	begin
		case (window)
			2'b00: win = tileA;
			2'b01: win = {tileB[63:0], tileA[127:64]};
			2'b10: win = tileB;
			default: win = {tileA[63:0], tileB[127:64]};
		endcase
	end

	assign shifted = win >> shift;
	assign exData = shifted[63:0];

	always_comb
	begin
		case (opm[2:0])
			3'b000: loadVal = {{56{exData[7]}}, exData[7:0]};
			3'b001: loadVal = {{48{exData[15]}}, exData[15:0]};
			3'b010: loadVal = {{32{exData[31]}}, exData[31:0]};
			3'b100: loadVal = {56'h0, exData[7:0]};
			3'b101: loadVal = {48'h0, exData[15:0]};
			3'b110: loadVal = {32'h0, exData[31:0]};
			default: loadVal = exData;
		endcase
	end

	always_comb
	begin
		case (opm[1:0])
			2'b00: merged = {exData[63:8], storeVal[7:0]};
			2'b01: merged = {exData[63:16], storeVal[15:0]};
			2'b10: merged = {exData[63:32], storeVal[31:0]};
			default: merged = storeVal;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (opm[4])
		begin
			winQ <= win;
			mergedQ <= merged;
		end
	end

	assign winW = (winQ & ~(laneMask << shift)) | ({64'h0, mergedQ} << shift);

	assign touchA = (window != 2'b10);
	assign touchB = (window != 2'b00);

	// split the written window back into bank tiles
	always_comb
	begin
		newTileA = tileA;
		newTileB = tileB;
		case (window)
			2'b00: newTileA = winW;
			2'b01:
			begin
				newTileA = {winW[63:0], tileA[63:0]};
				newTileB = {tileB[127:64], winW[127:64]};
			end
			2'b10: newTileB = winW;
			default:
			begin
				newTileB = {winW[63:0], tileB[63:0]};
				newTileA = {tileA[127:64], winW[127:64]};
			end
		endcase
	end

endmodule

// File: dcacheMiss.sv
`timescale 1ns/1ps

module dcacheMiss import dcachePkg::*; (
	input logic clock,
	input logic arstN,
	input logic missA,
	input logic missB,
	input tileAddrT reqTileA,
	input tileAddrT reqTileB,
	input tagT victimTagA,
	input tagT victimTagB,
	input tileT victimA,
	input tileT victimB,
	input tileT memDataIn,
	input okT memOk,
	output addrT memAddr,
	output opmT memOpm,
	output tileT memDataOut,
	output logic busy,
	output logic fillA,
	output logic fillB,
	output tileT fillData
);
	localparam logic [2:0] stIdle = 3'd0;
	localparam logic [2:0] stWrBack = 3'd1;
	localparam logic [2:0] stRdWait = 3'd2; // write-back done, wait for ready
	localparam logic [2:0] stRead = 3'd3;
	localparam logic [2:0] stDone = 3'd4;

	logic [2:0] state;
	logic serveB;
	logic selB;
	logic startReq;
	logic needWb;
	tagT victimTag;
	tileT victimData;
	tileAddrT reqTile;

	// bank A goes first
	assign selB = (state == stIdle) ? !missA : serveB;
	assign victimTag = selB ? victimTagB : victimTagA;
	assign victimData = selB ? victimB : victimA;
	assign reqTile = selB ? reqTileB : reqTileA;

	assign needWb = tagValid(victimTag) && tagDirty(victimTag);
	assign startReq = (missA || missB) && (memOk == okReady);
	assign busy = (state != stIdle);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			serveB <= 1'b0;
			memOpm <= opmReady;
			fillA <= 1'b0;
			fillB <= 1'b0;
		end
		else
		begin
			fillA <= 1'b0;
			fillB <= 1'b0;
			case (state)
				stIdle:
					if (startReq)
					begin
						serveB <= !missA;
						memOpm <= needWb ? opmWrTile : opmRdTile;
						state <= needWb ? stWrBack : stRead;
					end
				stWrBack:
					if (memOk == okOk)
					begin
						memOpm <= opmReady;
						state <= stRdWait;
					end
				stRdWait:
					if (memOk == okReady)
					begin
						memOpm <= opmRdTile;
						state <= stRead;
					end
				stRead:
					if (memOk == okOk)
					begin
						memOpm <= opmReady;
						fillA <= !serveB;
						fillB <= serveB;
						state <= stDone;
					end
				stDone:
					if (memOk == okReady)
						state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	// address and data stay put until the transfer is answered
	always_ff @(posedge clock)
	begin
		if ((state == stIdle) && startReq)
		begin
			memAddr <= needWb ? {tagTile(victimTag), 4'h0} : {reqTile, 4'h0};
			memDataOut <= victimData;
		end
		else if ((state == stRdWait) && (memOk == okReady))
			memAddr <= {reqTile, 4'h0};
		if ((state == stRead) && (memOk == okOk))
			fillData <= memDataIn;
	end

endmodule

// File: dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop import dcachePkg::*; #(
	parameter int bankDepth = defaultBankDepth
) (
	input logic clock,
	input logic arstN,
	input addrT reqAddr,
	input opmT reqOpm,
	input wordT reqVal,
	output wordT resVal,
	output okT resOk,
	output addrT memAddr,
	output opmT memOpm,
	output tileT memDataOut,
	input tileT memDataIn,
	input okT memOk
);
	localparam int ixW = $clog2(bankDepth);

	tileAddrT nxtTileA;
	tileAddrT nxtTileB;
	tileAddrT regTileA;
	tileAddrT regTileB;
	logic [4:0] regOff; // byte offset inside the even/odd pair
	opmT regOpm;
	wordT regVal;

	logic reqActive;
	logic isStore;
	logic storeCyc;
	logic missA;
	logic missB;
	logic baseHold;
	logic hold;
	logic storeWr;

	logic busy;
	logic fillA;
	logic fillB;
	tileT fillData;

	wordT loadVal;
	tileT newTileA;
	tileT newTileB;
	logic touchA;
	logic touchB;

	dcBankIf #(.bankDepth(bankDepth)) bankA ();
	dcBankIf #(.bankDepth(bankDepth)) bankB ();

	// even tile to A, odd tile to B
	always_comb
	begin
		if (reqAddr[4])
		begin
			nxtTileB = reqAddr[31:4];
			nxtTileA = nxtTileB + 1'b1;
		end
		else
		begin
			nxtTileA = reqAddr[31:4];
			nxtTileB = nxtTileA + 1'b1;
		end
	end

	assign reqActive = (regOpm[4:3] != 2'b00);
	assign isStore = regOpm[4];

	assign missA = reqActive && !(tagValid(bankA.rdTag) && tagTile(bankA.rdTag) == regTileA);
	assign missB = reqActive && !(tagValid(bankB.rdTag) && tagTile(bankB.rdTag) == regTileB);

	assign baseHold = reqActive && (missA || missB || busy || fillA || fillB);
	assign hold = baseHold || (isStore && !storeCyc);
	assign storeWr = isStore && storeCyc && !baseHold;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			regOpm <= '0;
			storeCyc <= 1'b0;
			resOk <= okReady;
		end
		else
		begin
			if (!hold)
				regOpm <= reqOpm;
			storeCyc <= isStore && !storeCyc && !baseHold;
			resOk <= hold ? okHold : (reqActive ? okOk : okReady);
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			regOff <= reqAddr[4:0];
			regVal <= reqVal;
			regTileA <= nxtTileA;
			regTileB <= nxtTileB;
		end
		resVal <= loadVal;
	end

	// re-read the held request so fills and stores show up
	assign bankA.rdIx = hold ? regTileA[ixW:1] : nxtTileA[ixW:1];
	assign bankA.wrEn = fillA || (storeWr && touchA);
	assign bankA.wrIx = regTileA[ixW:1];
	assign bankA.wrData = fillA ? fillData : newTileA;
	assign bankA.wrTag = makeTag(regTileA, !fillA); // fills are clean

	assign bankB.rdIx = hold ? regTileB[ixW:1] : nxtTileB[ixW:1];
	assign bankB.wrEn = fillB || (storeWr && touchB);
	assign bankB.wrIx = regTileB[ixW:1];
	assign bankB.wrData = fillB ? fillData : newTileB;
	assign bankB.wrTag = makeTag(regTileB, !fillB);

	dcacheBank #(.bankDepth(bankDepth)) uBankA (
		.clock(clock),
		.arstN(arstN),
		.port(bankA)
	);

	dcacheBank #(.bankDepth(bankDepth)) uBankB (
		.clock(clock),
		.arstN(arstN),
		.port(bankB)
	);

	dcacheAlign uAlign (
		.clock(clock),
		.byteIx(regOff[2:0]),
		.window(regOff[4:3]),
		.opm(regOpm),
		.storeVal(regVal),
		.tileA(bankA.rdData),
		.tileB(bankB.rdData),
		.loadVal(loadVal),
		.newTileA(newTileA),
		.newTileB(newTileB),
		.touchA(touchA),
		.touchB(touchB)
	);

	dcacheMiss uMiss (
		.clock(clock),
		.arstN(arstN),
		.missA(missA),
		.missB(missB),
		.reqTileA(regTileA),
		.reqTileB(regTileB),
		.victimTagA(bankA.rdTag),
		.victimTagB(bankB.rdTag),
		.victimA(bankA.rdData),
		.victimB(bankB.rdData),
		.memDataIn(memDataIn),
		.memOk(memOk),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataOut(memDataOut),
		.busy(busy),
		.fillA(fillA),
		.fillB(fillB),
		.fillData(fillData)
	);

endmodule

// File: dcacheTbMem.sv
`timescale 1ns/1ps

module dcacheTbMem import dcachePkg::*; #(
	parameter int memBytes = 4128,
	parameter logic [31:0] seedInit = 32'h9a746d93
) (
	input logic clock,
	input addrT memAddr,
	input opmT memOpm,
	input tileT memDataOut,
	output tileT memDataIn,
	output okT memOk
);
	logic [7:0] mem [memBytes];
	integer seed;
	int holdLeft;
	int i;
	int j;

	// same start pattern as the golden model
	function automatic logic [7:0] initByte(input int a);
		return 8'((a * 167) ^ (a >> 7));
	endfunction

	initial
	begin
		seed = seedInit;
		holdLeft = 0;
		memOk = okReady;
		memDataIn = '0;
		for (i = 0; i < memBytes; i++)
			mem[i] = initByte(i);
	end

	// answers on the falling edge
	always @(negedge clock)
	begin
		case (memOk)
			okReady:
				if (memOpm == opmRdTile || memOpm == opmWrTile)
				begin
					holdLeft = 1 + int'($unsigned($random(seed)) % 4); // 1 to 4 busy cycles
					memOk = okHold;
				end
			okHold:
			begin
				holdLeft = holdLeft - 1;
				if (holdLeft == 0)
				begin
					for (j = 0; j < 16; j++)
					begin
						if (memOpm == opmWrTile)
							mem[(memAddr + j) % memBytes] = memDataOut[8*j +: 8];
						else
							memDataIn[8*j +: 8] = mem[(memAddr + j) % memBytes];
					end
					memOk = okOk;
				end
			end
			default:
				if (memOpm == opmReady)
					memOk = okReady; // cache closed the transfer
		endcase
	end

endmodule

// File: dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb import dcachePkg::*; ();
	localparam int numOps = 2000;
	localparam int winBytes = 4096;
	localparam int memBytes = winBytes + 32; // pair fetch reaches past the window
	localparam int resetCycles = 8;
	// two write-backs and two reads of up to 6 cycles, plus request and drain cycles
	localparam int opCycles = 36;
	localparam int cycleLimit = numOps * opCycles + resetCycles + 20;

	logic clock;
	logic arstN;
	addrT reqAddr;
	opmT reqOpm;
	wordT reqVal;
	wordT resVal;
	okT resOk;
	addrT memAddr;
	opmT memOpm;
	tileT memDataOut;
	tileT memDataIn;
	okT memOk;

	logic [7:0] golden [memBytes];
	integer seed;
	int cycles = 0;
	logic inXfer = 1'b0;
	addrT xferAddr;
	opmT xferOpm;
	tileT xferData;
	int lastAddr;
	int i;
	int n;

	dcacheTop #(.bankDepth(16)) uut (
		.clock(clock),
		.arstN(arstN),
		.reqAddr(reqAddr),
		.reqOpm(reqOpm),
		.reqVal(reqVal),
		.resVal(resVal),
		.resOk(resOk),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataOut(memDataOut),
		.memDataIn(memDataIn),
		.memOk(memOk)
	);

	dcacheTbMem #(.memBytes(memBytes), .seedInit(32'h9a746d93)) uMem (
		.clock(clock),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataOut(memDataOut),
		.memDataIn(memDataIn),
		.memOk(memOk)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic compareVal(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	function automatic logic [7:0] initByte(input int a);
		return 8'((a * 167) ^ (a >> 7));
	endfunction

	// little endian, extended by the size and unsigned bits
	function automatic wordT expectLoad(input int addr, input opmT opm);
		wordT raw;
		int nBytes;
		int k;
		raw = '0;
		nBytes = 1 << opm[1:0];
		for (k = 0; k < nBytes; k++)
			raw[8*k +: 8] = golden[addr + k];
		if (!opm[2] && nBytes < 8 && raw[8*nBytes-1])
			for (k = nBytes; k < 8; k++)
				raw[8*k +: 8] = 8'hff;
		return raw;
	endfunction

	task automatic storeGolden(input int addr, input opmT opm, input wordT val);
		int k;
		for (k = 0; k < (1 << opm[1:0]); k++)
			golden[addr + k] = val[8*k +: 8];
	endtask

	function automatic tileT goldenTile(input int addr);
		tileT t;
		int k;
		for (k = 0; k < 16; k++)
			t[8*k +: 8] = golden[addr + k];
		return t;
	endfunction

	task automatic waitStatus(input okT want);
		do
			@(negedge clock);
		while (resOk != want);
	endtask

	task automatic runOp(input int idx);
		int addr;
		opmT opm;
		wordT val;
		wordT expected;
		logic isStore;
		isStore = 1'($random(seed));
		opm = {isStore, !isStore, 1'($random(seed)), 2'($random(seed))};
		addr = int'($unsigned($random(seed)) % winBytes);
		if (idx > 0 && ($unsigned($random(seed)) % 4) == 0)
			addr = lastAddr; // overlap the previous access
		val = {$random(seed), $random(seed)};
		expected = expectLoad(addr, opm);
		reqAddr = addr;
		reqOpm = opm;
		reqVal = val;
		waitStatus(okOk);
		if (isStore)
			storeGolden(addr, opm, val);
		else
			compareVal($sformatf("load %0d at %0h opm %b", idx, addr, opm), expected, resVal);
		reqOpm = '0;
		waitStatus(okReady); // repeated request drains
		lastAddr = addr;
	endtask

	// memory bus rules, sampled at the rising edge
	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles > cycleLimit)
		begin
			$display("timeout, cache stopped answering after %0d cycles", cycles);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
		else if (memOk == okHold || memOk == okOk)
		begin
			if (!inXfer)
			begin
				xferAddr = memAddr;
				xferOpm = memOpm;
				xferData = memDataOut;
				compareVal("transfer address alignment", 4'h0, memAddr[3:0]);
				compareVal("transfer address range", 1'b1, memAddr <= memBytes - 16);
			end
			else
			begin
				compareVal("memOpm stable during hold", xferOpm, memOpm);
				compareVal("memAddr stable during hold", xferAddr, memAddr);
				compareVal("memDataOut stable during hold", xferData, memDataOut);
			end
			inXfer = 1'b1;
			if (memOk == okOk && memOpm == opmWrTile)
				compareVal($sformatf("write-back of tile at %0h", memAddr),
					goldenTile(int'(memAddr)), memDataOut);
		end
		else
			inXfer = 1'b0;
	end

	initial
	begin
		seed = 32'h9a746d93;
		arstN = 1'b0;
		reqAddr = '0;
		reqOpm = '0;
		reqVal = '0;
		lastAddr = 0;
		for (i = 0; i < memBytes; i++)
			golden[i] = initByte(i);
		repeat (resetCycles) @(negedge clock);
		arstN = 1'b1;
		@(negedge clock);
		compareVal("resOk after reset", okReady, resOk);
		compareVal("memOpm after reset", opmReady, memOpm);
		for (n = 0; n < numOps; n++)
			runOp(n);
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: dcache.f
dcachePkg.sv
dcBankIf.sv
dcacheBank.sv
dcacheAlign.sv
dcacheMiss.sv
dcacheTop.sv
dcacheTbMem.sv
dcacheTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the pass line
rm -f sim.log &&
	verilator --binary --timing -Wno-fatal --top-module dcacheTb -f dcache.f > build.log 2>&1 &&
	{ ./obj_dir/VdcacheTb > sim.log 2>&1 || true; } &&
	grep -qx "TEST PASS" sim.log &&
	echo "dcache simulation passed" ||
	{ echo "dcache simulation failed, see build.log and sim.log"; exit 1; }
